/* acc_defs.svh */
`ifndef ACC_DEFS_SVH
`define ACC_DEFS_SVH

// ---------------------------------------
// tile geometry
// ---------------------------------------
`define ROW_NUM   32    // pe rows per tile
`define DW_GROUPS 10    // three-row groups in dw mode, rows 0..29

// ---------------------------------------
// datapath widths
// ---------------------------------------
`define ACT_W     8     // activation and weight
`define PSUM_W    16    // partial sum, wraps on overflow

`endif

/* acc_pkg.sv */
package acc_pkg;

    // ---------------------------------------
    // layer type, top two bits of the command
    // ---------------------------------------
    typedef enum logic [1:0] {
        LAYER_PW   = 2'd0,  // point-wise, per-row accumulate
        LAYER_DW   = 2'd1,  // depth-wise / conv, three rows into one
        LAYER_RSV2 = 2'd2,  // reserved, zero output
        LAYER_RSV3 = 2'd3   // reserved, zero output
    } layer_type_e;

    // pw reading of the command word
    typedef struct packed {
        layer_type_e layer_type;  // [15:14]
        logic        clear_first; // [13] start from zero
        logic [4:0]  rsvd;        // [12:8]
        logic [7:0]  beats;       // [7:0] beats in the pass
    } pw_cmd_t;

    // dw reading, shift field sits where pw has reserved bits
    typedef struct packed {
        layer_type_e layer_type;  // [15:14]
        logic        clear_first; // [13]
        logic [3:0]  out_shift;   // [12:9] arithmetic right shift on output
        logic        rsvd;        // [8]
        logic [7:0]  beats;       // [7:0]
    } dw_cmd_t;

    typedef union packed {
        pw_cmd_t pw;
        dw_cmd_t dw;
    } pass_cmd_u;

endpackage

/* opsum_buffer.sv */
`timescale 1ns/1ps
`include "acc_defs.svh"

module opsum_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          prod_valid,
    input  logic                          prod_first,
    input  logic                          prod_last,
    input  logic                          clear_first,
    input  logic [3:0]                    out_shift,
    input  logic [`ROW_NUM*`PSUM_W-1:0]   sum_row,
    output logic [`ROW_NUM*`PSUM_W-1:0]   ipsum_row,
    output logic                          out_valid,
    output logic [`ROW_NUM*`PSUM_W-1:0]   opsum
);

    logic [`ROW_NUM*`PSUM_W-1:0] psum_q;  // running partial sums, all rows

    // ---------------------------------------
    // feedback to the reducer
    // ---------------------------------------
    // first beat of a cleared pass starts from zero
    assign ipsum_row = (prod_first && clear_first) ? '0 : psum_q;

    // ---------------------------------------
    // partial-sum registers
    // ---------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            psum_q <= '0;  // buffer starts empty
        end else if (prod_valid) begin
            psum_q <= sum_row;
        end
        // kept between passes, accumulates when clear is off
    end

    // ---------------------------------------
    // output stage
    // ---------------------------------------
    // captured from the last write itself, so the shift of this pass is used
    // even when the next command already changed out_shift
    always_ff @(posedge clk) begin
        if (prod_last) begin
            for (int k = 0; k < `ROW_NUM; k++) begin
                opsum[k*`PSUM_W +: `PSUM_W] <= $signed(sum_row[k*`PSUM_W +: `PSUM_W])
                                             >>> out_shift;  // sign fill
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= prod_last;  // one cycle after the last product
        end
    end

    // passes are at least one beat plus a command apart
    a_single_strobe : assert property (
        @(posedge clk) disable iff (rst) out_valid |=> !out_valid
    );

endmodule

/* pass_decoder.sv */
`timescale 1ns/1ps

module pass_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cmd_valid,
    input  logic [15:0]            cmd_word,
    input  logic                   in_valid,
    output logic                   busy,
    output logic                   beat_fire,
    output acc_pkg::layer_type_e   layer_type,
    output logic                   clear_first,
    output logic [3:0]             out_shift,
    output logic                   first_beat,
    output logic                   last_beat
);

    acc_pkg::pass_cmd_u cmd;       // same word, pw and dw views
    logic [7:0]         beat_cnt;  // beats still to come
    logic               first_pend; // no beat taken yet this pass

    assign cmd = cmd_word;

    // ---------------------------------------
    // beat qualification
    // ---------------------------------------
    assign beat_fire  = in_valid & busy;  // strobes outside a pass are dropped
    assign first_beat = beat_fire & first_pend;
    assign last_beat  = beat_fire & (beat_cnt == 8'd1);

    // ---------------------------------------
    // command latch and beat counter
    // ---------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            beat_cnt    <= 8'd0;
            first_pend  <= 1'b0;
            layer_type  <= acc_pkg::LAYER_PW;
            clear_first <= 1'b0;
            out_shift   <= 4'd0;
        end else if (cmd_valid && !busy) begin
            busy        <= 1'b1;  // busy from the next cycle
            beat_cnt    <= cmd.pw.beats;
            first_pend  <= 1'b1;
            layer_type  <= cmd.pw.layer_type;
            clear_first <= cmd.pw.clear_first;
            // shift field only means something in dw
            if (cmd.dw.layer_type == acc_pkg::LAYER_DW) begin
                out_shift <= cmd.dw.out_shift;
            end else begin
                out_shift <= 4'd0;
            end
        end else if (beat_fire) begin
            beat_cnt   <= beat_cnt - 8'd1;
            first_pend <= 1'b0;
            if (last_beat) begin
                busy <= 1'b0;  // next command may land right away
            end
        end
    end

    // type, flag and shift stay put until the next command,
    // the buffer still reads them a cycle after the last beat

    // a command on top of a running pass would be lost
    a_no_cmd_when_busy : assert property (
        @(posedge clk) disable iff (rst) cmd_valid |-> !busy
    );

    // zero beats would leave busy stuck high
    a_beats_nonzero : assert property (
        @(posedge clk) disable iff (rst) cmd_valid |-> (cmd.pw.beats != 8'd0)
    );

endmodule

/* pass_engine.sv */
`timescale 1ns/1ps
`include "acc_defs.svh"

module pass_engine (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid,
    input  logic [15:0]                   cmd_word,
    input  logic                          in_valid,
    input  logic [`ROW_NUM*`ACT_W-1:0]    ifmap_row,
    input  logic [`ROW_NUM*`ACT_W-1:0]    weight_row,
    output logic                          out_valid,
    output logic [`ROW_NUM*`PSUM_W-1:0]   opsum,
    output logic                          busy
);

    // ---------------------------------------
    // decode to execute
    // ---------------------------------------
    logic                  beat_fire;
    logic                  first_beat;
    logic                  last_beat;
    acc_pkg::layer_type_e  layer_type;
    logic                  clear_first;
    logic [3:0]            out_shift;  // zero unless dw

    // ---------------------------------------
    // execute to result
    // ---------------------------------------
    logic [`ROW_NUM*`PSUM_W-1:0] prod_row;
    logic                        prod_valid;
    logic                        prod_first;
    logic                        prod_last;
    logic [`ROW_NUM*`PSUM_W-1:0] ipsum_row;  // buffer feedback
    logic [`ROW_NUM*`PSUM_W-1:0] sum_row;    // reducer result

    pass_decoder i_decoder (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_word    (cmd_word),
        .in_valid    (in_valid),
        .busy        (busy),
        .beat_fire   (beat_fire),
        .layer_type  (layer_type),
        .clear_first (clear_first),
        .out_shift   (out_shift),
        .first_beat  (first_beat),
        .last_beat   (last_beat)
    );

    pe_row_array i_array (
        .clk        (clk),
        .rst        (rst),
        .beat_fire  (beat_fire),
        .first_beat (first_beat),
        .last_beat  (last_beat),
        .ifmap_row  (ifmap_row),
        .weight_row (weight_row),
        .prod_row   (prod_row),
        .prod_valid (prod_valid),
        .prod_first (prod_first),
        .prod_last  (prod_last)
    );

    // combinational, same cycle as the registered product
    psum_reducer i_reducer (
        .prod_row   (prod_row),
        .ipsum_row  (ipsum_row),
        .layer_type (layer_type),
        .sum_row    (sum_row)
    );

    opsum_buffer i_opsum (
        .clk         (clk),
        .rst         (rst),
        .prod_valid  (prod_valid),
        .prod_first  (prod_first),
        .prod_last   (prod_last),
        .clear_first (clear_first),
        .out_shift   (out_shift),
        .sum_row     (sum_row),
        .ipsum_row   (ipsum_row),
        .out_valid   (out_valid),
        .opsum       (opsum)
    );

endmodule

/* pe_row_array.sv */
`timescale 1ns/1ps
`include "acc_defs.svh"

module pe_row_array (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          beat_fire,
    input  logic                          first_beat,
    input  logic                          last_beat,
    input  logic [`ROW_NUM*`ACT_W-1:0]    ifmap_row,
    input  logic [`ROW_NUM*`ACT_W-1:0]    weight_row,
    output logic [`ROW_NUM*`PSUM_W-1:0]   prod_row,
    output logic                          prod_valid,
    output logic                          prod_first,
    output logic                          prod_last
);

    // one signed 8x8 multiply per row, full 16-bit product
    always_ff @(posedge clk) begin
        if (beat_fire) begin
            for (int k = 0; k < `ROW_NUM; k++) begin
                prod_row[k*`PSUM_W +: `PSUM_W] <= $signed(ifmap_row[k*`ACT_W +: `ACT_W])
                                                * $signed(weight_row[k*`ACT_W +: `ACT_W]);
            end
        end
    end

    // beat flags ride along with the product
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_valid <= 1'b0;
            prod_first <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= beat_fire;
            prod_first <= beat_fire & first_beat;
            prod_last  <= beat_fire & last_beat;
        end
    end

    // first and last flags only ever come with a fired beat
    a_flags_need_beat : assert property (
        @(posedge clk) disable iff (rst) (first_beat || last_beat) |-> beat_fire
    );

endmodule

/* psum_reducer.sv */
`timescale 1ns/1ps
`include "acc_defs.svh"

module psum_reducer (
    input  logic [`ROW_NUM*`PSUM_W-1:0]  prod_row,
    input  logic [`ROW_NUM*`PSUM_W-1:0]  ipsum_row,
    input  acc_pkg::layer_type_e         layer_type,
    output logic [`ROW_NUM*`PSUM_W-1:0]  sum_row
);

    logic [`PSUM_W-1:0] prod_in  [`ROW_NUM];   // unpacked per row
    logic [`PSUM_W-1:0] ipsum_in [`ROW_NUM];
    logic [`PSUM_W-1:0] pw_sum   [`ROW_NUM];   // one row each
    logic [`PSUM_W-1:0] dw_sum   [`DW_GROUPS]; // three rows each

    // ---------------------------------------
    // pw adders
    // ---------------------------------------
    genvar k;
    generate
        for (k = 0; k < `ROW_NUM; k = k + 1) begin : g_pw
            assign prod_in[k]  = prod_row[k*`PSUM_W +: `PSUM_W];
            assign ipsum_in[k] = ipsum_row[k*`PSUM_W +: `PSUM_W];
            assign pw_sum[k]   = ipsum_in[k] + prod_in[k];  // wraps at 16 bits
        end
    endgenerate

    // ---------------------------------------
    // dw / conv three-row adders
    // ---------------------------------------
    genvar m;
    generate
        for (m = 0; m < `DW_GROUPS; m = m + 1) begin : g_dw
            // ipsum of the group head row is the running sum
            assign dw_sum[m] = ipsum_in[m*3] + prod_in[m*3]
                             + prod_in[m*3 + 1] + prod_in[m*3 + 2];
        end
    endgenerate

    // ---------------------------------------
    // output select by layer type
    // ---------------------------------------
    genvar n;
    generate
        for (n = 0; n < `ROW_NUM; n = n + 1) begin : g_out
            if ((n < 3*`DW_GROUPS) && ((n % 3) == 0)) begin : g_head
                // group head, pw or dw result
                assign sum_row[n*`PSUM_W +: `PSUM_W] =
                    (layer_type == acc_pkg::LAYER_PW) ? pw_sum[n] :
                    (layer_type == acc_pkg::LAYER_DW) ? dw_sum[n/3] : '0;
            end else begin : g_other
                // rows 3m+1, 3m+2 and the tail rows are zero outside pw
                assign sum_row[n*`PSUM_W +: `PSUM_W] =
                    (layer_type == acc_pkg::LAYER_PW) ? pw_sum[n] : '0;
            end
        end
    endgenerate

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the pass_engine testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_pass_engine -f sim.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

/* sim.f */
+incdir+.
acc_pkg.sv
pass_decoder.sv
pe_row_array.sv
psum_reducer.sv
opsum_buffer.sv
pass_engine.sv
tb_clkgen.sv
tb_pass_engine.sv

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // rst held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

/* tb_pass_engine.sv */
`timescale 1ns/1ps
`include "acc_defs.svh"

module tb_pass_engine;

    localparam int AW = `ROW_NUM*`ACT_W;   // activation / weight bus
    localparam int PW = `ROW_NUM*`PSUM_W;  // opsum bus
    // beats of all passes, pass count, gapped beats, idle strobes
    localparam int CYCLE_LIMIT = 52 + 4*9 + 2*10 + 3 + 50;

    logic          clk;
    logic          rst;
    logic          cmd_valid;
    logic [15:0]   cmd_word;
    logic          in_valid;
    logic [AW-1:0] ifmap_row;
    logic [AW-1:0] weight_row;
    logic          out_valid;
    logic [PW-1:0] opsum;
    logic          busy;

    int            seed = 10402;
    int            errors = 0;
    int            outs_seen = 0;
    int            cycle_cnt = 0;
    logic [PW-1:0] model_psum = '0;   // unshifted buffer contents
    logic [PW-1:0] exp_q [$];         // expected opsum per pass
    logic [PW-1:0] exp_opsum;
    logic [PW-1:0] last_opsum = '0;
    logic [PW-1:0] b2b_out;
    logic [AW-1:0] ifm_mem [16];
    logic [AW-1:0] wgt_mem [16];

    tb_clkgen i_clkgen (.clk(clk), .rst(rst));

    pass_engine i_dut (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_word   (cmd_word),
        .in_valid   (in_valid),
        .ifmap_row  (ifmap_row),
        .weight_row (weight_row),
        .out_valid  (out_valid),
        .opsum      (opsum),
        .busy       (busy)
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    // one beat applied to the model state
    function automatic logic [PW-1:0] apply_beat(input logic [PW-1:0] state,
                                                 input acc_pkg::layer_type_e ltype,
                                                 input logic from_zero,
                                                 input logic [AW-1:0] ifm,
                                                 input logic [AW-1:0] wgt);
        logic [PW-1:0]         base;
        logic [PW-1:0]         nxt;
        logic [`ACT_W-1:0]     a;
        logic [`ACT_W-1:0]     w;
        logic [`PSUM_W-1:0]    r;
        int                    prod [`ROW_NUM];
        int                    sum;
        base = from_zero ? '0 : state;  // cleared pass starts from zero
        nxt  = '0;                      // reserved types and unused rows
        for (int k = 0; k < `ROW_NUM; k++) begin
            a = ifm[k*`ACT_W +: `ACT_W];
            w = wgt[k*`ACT_W +: `ACT_W];
            prod[k] = {{24{a[7]}}, a} * {{24{w[7]}}, w};
        end
        for (int k = 0; k < `ROW_NUM; k++) begin
            r = base[k*`PSUM_W +: `PSUM_W];
            if (ltype == acc_pkg::LAYER_PW) begin
                sum = {{16{r[15]}}, r} + prod[k];
                nxt[k*`PSUM_W +: `PSUM_W] = sum[15:0];  // wrap
            end else if (ltype == acc_pkg::LAYER_DW && k % 3 == 0 && k < 3*`DW_GROUPS) begin
                sum = {{16{r[15]}}, r} + prod[k] + prod[k+1] + prod[k+2];
                nxt[k*`PSUM_W +: `PSUM_W] = sum[15:0];
            end
        end
        return nxt;
    endfunction

    // arithmetic right shift of every row
    function automatic logic [PW-1:0] shift_rows(input logic [PW-1:0] state,
                                                 input logic [3:0] shift);
        logic [PW-1:0]      res;
        logic [`PSUM_W-1:0] r;
        int                 v;
        for (int k = 0; k < `ROW_NUM; k++) begin
            r = state[k*`PSUM_W +: `PSUM_W];
            v = {{16{r[15]}}, r};
            v = v >>> shift;
            res[k*`PSUM_W +: `PSUM_W] = v[15:0];
        end
        return res;
    endfunction

    // ----------------------------------------
    // compare process, sampled mid-cycle
    // ----------------------------------------
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid arrived at %0t with no pass outstanding", $time);
                errors++;
            end else begin
                exp_opsum = exp_q.pop_front();
                for (int k = 0; k < `ROW_NUM; k++) begin
                    if (opsum[k*`PSUM_W +: `PSUM_W] !== exp_opsum[k*`PSUM_W +: `PSUM_W]) begin
                        $display("** Error: opsum[%0d] expected %h actual %h", k,
                                 exp_opsum[k*`PSUM_W +: `PSUM_W],
                                 opsum[k*`PSUM_W +: `PSUM_W]);
                        errors++;
                    end
                end
            end
            last_opsum = opsum;
            outs_seen++;
        end
    end

    // timeout backstop
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing, %0d errors",
                     cycle_cnt, errors);
            $display("Errors found");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus tasks, all start at edge + 2 ns
    // ----------------------------------------
    task automatic fill_random(input int n);
        for (int b = 0; b < n; b++) begin
            for (int j = 0; j < AW/32; j++) begin
                ifm_mem[b][j*32 +: 32] = $random(seed);
                wgt_mem[b][j*32 +: 32] = $random(seed);
            end
        end
    endtask

    task automatic run_pass(input acc_pkg::layer_type_e ltype, input logic clr,
                            input logic [3:0] shift, input int beats, input bit gapped);
        acc_pkg::pass_cmd_u cmd;
        logic [3:0]         eff_shift;
        int                 gap;
        int                 seen_before;
        int                 wait_cnt;
        cmd = '0;
        if (ltype == acc_pkg::LAYER_DW) begin
            cmd.dw.layer_type  = ltype;
            cmd.dw.clear_first = clr;
            cmd.dw.out_shift   = shift;
            cmd.dw.beats       = beats[7:0];
            eff_shift          = shift;
        end else begin
            cmd.pw.layer_type  = ltype;   // no shift field in this view
            cmd.pw.clear_first = clr;
            cmd.pw.beats       = beats[7:0];
            eff_shift          = 4'd0;
        end
        seen_before = outs_seen;
        cmd_valid = 1'b1;
        cmd_word  = cmd;
        @(posedge clk);
        #2 cmd_valid = 1'b0;
        if (busy !== 1'b1) begin
            $display("** Error: busy expected %h actual %h", 1'b1, busy);
            errors++;
        end
        for (int b = 0; b < beats; b++) begin
            in_valid   = 1'b1;
            ifmap_row  = ifm_mem[b];
            weight_row = wgt_mem[b];
            model_psum = apply_beat(model_psum, ltype, clr && b == 0, ifm_mem[b], wgt_mem[b]);
            if (b == beats - 1) begin
                exp_q.push_back(shift_rows(model_psum, eff_shift));
            end
            @(posedge clk);
            #2 in_valid = 1'b0;
            if (gapped && b != beats - 1) begin
                gap = $unsigned($random(seed)) % 3;  // 0..2 idle cycles
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                end
            end
        end
        wait_cnt = 0;
        while (outs_seen == seen_before && wait_cnt < 8) begin
            @(posedge clk);
            #2 wait_cnt++;
        end
        if (outs_seen == seen_before) begin
            $display("out_valid never arrived for a pass of %0d beats", beats);
            errors++;
            exp_q.delete();
        end
        repeat (2) begin
            @(posedge clk);
            #2;
        end
        if (outs_seen != seen_before + 1) begin
            $display("pass of %0d beats gave %0d output strobes", beats, outs_seen - seen_before);
            errors++;
        end
        if (busy !== 1'b0) begin
            $display("** Error: busy expected %h actual %h", 1'b0, busy);
            errors++;
        end
    endtask

    // strobes with no pass open, must be dropped
    task automatic idle_beats(input int n);
        for (int b = 0; b < n; b++) begin
            in_valid   = 1'b1;
            ifmap_row  = ifm_mem[b];
            weight_row = wgt_mem[b];
            @(posedge clk);
            #2 in_valid = 1'b0;
        end
    endtask

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin
        cmd_valid  = 1'b0;
        cmd_word   = '0;
        in_valid   = 1'b0;
        ifmap_row  = '0;
        weight_row = '0;
        @(posedge clk);
        while (rst) @(posedge clk);
        #2;

        // pw from zero
        fill_random(8);
        run_pass(acc_pkg::LAYER_PW, 1'b1, 4'd0, 8, 1'b0);

        // dw with shift, non-head rows must read zero
        fill_random(6);
        run_pass(acc_pkg::LAYER_DW, 1'b1, 4'd3, 6, 1'b0);
        for (int k = 0; k < `ROW_NUM; k++) begin
            if ((k % 3 != 0 || k >= 3*`DW_GROUPS) && last_opsum[k*`PSUM_W +: `PSUM_W] !== '0) begin
                $display("** Error: opsum[%0d] expected %h actual %h", k, 16'h0000,
                         last_opsum[k*`PSUM_W +: `PSUM_W]);
                errors++;
            end
        end

        // accumulate across two pw passes
        fill_random(5);
        run_pass(acc_pkg::LAYER_PW, 1'b1, 4'd0, 5, 1'b0);
        fill_random(4);
        run_pass(acc_pkg::LAYER_PW, 1'b0, 4'd0, 4, 1'b0);

        // same data back-to-back then gapped
        fill_random(10);
        run_pass(acc_pkg::LAYER_PW, 1'b1, 4'd0, 10, 1'b0);
        b2b_out = last_opsum;
        run_pass(acc_pkg::LAYER_PW, 1'b1, 4'd0, 10, 1'b1);
        for (int k = 0; k < `ROW_NUM; k++) begin
            if (last_opsum[k*`PSUM_W +: `PSUM_W] !== b2b_out[k*`PSUM_W +: `PSUM_W]) begin
                $display("** Error: opsum[%0d] gapped %h back-to-back %h", k,
                         last_opsum[k*`PSUM_W +: `PSUM_W], b2b_out[k*`PSUM_W +: `PSUM_W]);
                errors++;
            end
        end

        // reserved type zeroes the output, idle strobes ignored
        fill_random(3);
        run_pass(acc_pkg::LAYER_RSV3, 1'b0, 4'd0, 3, 1'b0);
        fill_random(4);
        run_pass(acc_pkg::LAYER_PW, 1'b1, 4'd0, 4, 1'b0);
        fill_random(3);
        idle_beats(3);
        fill_random(2);
        run_pass(acc_pkg::LAYER_PW, 1'b0, 4'd0, 2, 1'b0);

        repeat (3) @(posedge clk);
        $display("checks done, %0d errors, %0d outputs", errors, outs_seen);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
